// ==== Bender.yml ====
package:
  name: i2s_audio_out

sources:
  - common/i2s_pkg.sv
  - source/sample_fifo.sv
  - source/gain_stage.sv
  - i2s_tx/audio_timing.sv
  - i2s_tx/i2s_serializer.sv
  - source/i2s_audio_out.sv
  - target: test
    files:
      - test/i2s_checker.sv
      - test/tb_i2s_audio_out.sv

// ==== common/i2s_pkg.sv ====
`default_nettype none

package i2s_pkg;

	// sample and slot width.
	localparam int SAMPLE_WIDTH = 16; // one i2s slot per channel.

	// volume field.
	localparam int GAIN_WIDTH = 8;

	// 128 is unity, 255 is just under 2x.
	localparam int GAIN_SHIFT = 7;

	// signed audio sample.
	typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

	// unsigned volume.
	typedef logic [GAIN_WIDTH-1:0] gain_t;

endpackage

`default_nettype wire

// ==== i2s_audio_out.f ====
common/i2s_pkg.sv
source/sample_fifo.sv
source/gain_stage.sv
i2s_tx/audio_timing.sv
i2s_tx/i2s_serializer.sv
source/i2s_audio_out.sv
test/i2s_checker.sv
test/tb_i2s_audio_out.sv

// ==== i2s_tx/audio_timing.sv ====
`default_nettype none

module audio_timing #(
	parameter int CLK_RATE = 24576000,
	parameter int AUDIO_RATE = 48000
) (
	input wire clk,
	input wire reset,

	output logic sample_tick,
	output logic bclk,
	output logic lrclk,
	output logic shift_strobe,
	output logic load_strobe
);

	// two slots per frame, halved for the toggle.
	localparam int BCLK_COUNT = CLK_RATE / (AUDIO_RATE * i2s_pkg::SAMPLE_WIDTH * 2) / 2;
	localparam int LRCLK_COUNT = BCLK_COUNT * 2 * i2s_pkg::SAMPLE_WIDTH;
	localparam int FRAME_COUNT = LRCLK_COUNT * 2; // left plus right.

	localparam int BCLK_CW = (BCLK_COUNT > 1) ? $clog2(BCLK_COUNT) : 1;
	localparam int LRCLK_CW = $clog2(LRCLK_COUNT);
	localparam int FRAME_CW = $clog2(FRAME_COUNT);

	logic [BCLK_CW-1:0] bclk_count;
	logic [LRCLK_CW-1:0] lrclk_count;
	logic [FRAME_CW-1:0] frame_count;
	logic bclk_prev;
	logic bclk_end;
	logic lrclk_end;
	logic frame_end;

	assign bclk_end = bclk_count == BCLK_CW'(BCLK_COUNT - 1);
	assign lrclk_end = lrclk_count == LRCLK_CW'(LRCLK_COUNT - 1);
	assign frame_end = frame_count == FRAME_CW'(FRAME_COUNT - 1);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			bclk_count <= '0;
			lrclk_count <= '0;
			frame_count <= '0;
			sample_tick <= 1'b0;
			bclk <= 1'b0;
			bclk_prev <= 1'b0;
			lrclk <= 1'b0;
			load_strobe <= 1'b0;
		end else begin
			bclk_count <= bclk_end ? '0 : bclk_count + 1'b1;
			lrclk_count <= lrclk_end ? '0 : lrclk_count + 1'b1;
			frame_count <= frame_end ? '0 : frame_count + 1'b1;
			sample_tick <= frame_end;
			if (bclk_end)
				bclk <= ~bclk;
			if (lrclk_end)
				lrclk <= ~lrclk; // low is the left channel.
			bclk_prev <= bclk;
			load_strobe <= lrclk_count == '0; // cycle after the word clock edge.
		end
	end

	// cycle after the falling bit clock edge.
	assign shift_strobe = bclk_prev & ~bclk;

endmodule

`default_nettype wire

// ==== i2s_tx/i2s_serializer.sv ====
`default_nettype none

module i2s_serializer (
	input wire clk,
	input wire reset,

	input wire sample_tick,
	input wire lrclk,
	input wire load_strobe,
	input wire shift_strobe,

	input wire i2s_pkg::sample_t proc_left,
	input wire i2s_pkg::sample_t proc_right,

	output logic sdata
);

	localparam int W = i2s_pkg::SAMPLE_WIDTH;

	i2s_pkg::sample_t shadow_left;
	i2s_pkg::sample_t shadow_right;
	logic [W-1:0] shift_reg;

	// frame to send during the next frame period.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			shadow_left <= '0;
			shadow_right <= '0;
		end else if (sample_tick) begin
			shadow_left <= proc_left;
			shadow_right <= proc_right;
		end
	end

	// load wins over shift.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			shift_reg <= '0;
		end else if (load_strobe) begin
			shift_reg <= lrclk ? shadow_right : shadow_left;
		end else if (shift_strobe) begin
			shift_reg <= {shift_reg[W-2:0], 1'b0}; // msb first.
		end
	end

	// left-justified, no one-bit delay.
	assign sdata = shift_reg[W-1];

endmodule

`default_nettype wire

// ==== source/gain_stage.sv ====
`default_nettype none

module gain_stage (
	input wire clk,
	input wire reset,

	input wire i2s_pkg::sample_t fifo_left,
	input wire i2s_pkg::sample_t fifo_right,
	input wire i2s_pkg::gain_t fifo_volume,
	input wire proc_update,

	output i2s_pkg::sample_t proc_left,
	output i2s_pkg::sample_t proc_right
);

	// sample times signed-extended volume.
	localparam int PROD_W = i2s_pkg::SAMPLE_WIDTH + i2s_pkg::GAIN_WIDTH + 1;
	localparam logic signed [PROD_W-1:0] SAT_MAX = (2 ** (i2s_pkg::SAMPLE_WIDTH - 1)) - 1;
	localparam logic signed [PROD_W-1:0] SAT_MIN = -(2 ** (i2s_pkg::SAMPLE_WIDTH - 1));

	// scale, shift down and clamp one channel.
	function automatic i2s_pkg::sample_t scale(
		input i2s_pkg::sample_t sample,
		input i2s_pkg::gain_t volume
	);
		logic signed [PROD_W-1:0] product;
		logic signed [PROD_W-1:0] shifted;
		product = sample * $signed({1'b0, volume});
		shifted = product >>> i2s_pkg::GAIN_SHIFT; // rounds toward minus infinity.
		if (shifted > SAT_MAX)
			return i2s_pkg::sample_t'(SAT_MAX);
		else if (shifted < SAT_MIN)
			return i2s_pkg::sample_t'(SAT_MIN);
		else
			return i2s_pkg::sample_t'(shifted);
	endfunction

	i2s_pkg::sample_t scaled_left;
	i2s_pkg::sample_t scaled_right;

	assign scaled_left = scale(fifo_left, fifo_volume);
	assign scaled_right = scale(fifo_right, fifo_volume);

	// held until the next pop.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			proc_left <= '0;
			proc_right <= '0;
		end else if (proc_update) begin
			proc_left <= scaled_left;
			proc_right <= scaled_right;
		end
	end

endmodule

`default_nettype wire

// ==== source/i2s_audio_out.sv ====
`default_nettype none

module i2s_audio_out #(
	parameter int CLK_RATE = 24576000,
	parameter int AUDIO_RATE = 48000,
	parameter int FIFO_DEPTH = 4 // power of two.
) (
	input wire clk,
	input wire reset,

	input wire sample_write,
	input wire i2s_pkg::sample_t write_left,
	input wire i2s_pkg::sample_t write_right,
	input wire i2s_pkg::gain_t write_volume,

	output wire fifo_full,
	output wire overflow,
	output wire underrun,

	output wire bclk,
	output wire lrclk,
	output wire sdata
);

	wire sample_tick;
	wire load_strobe;
	wire shift_strobe;
	wire fifo_update;
	wire i2s_pkg::sample_t fifo_left;
	wire i2s_pkg::sample_t fifo_right;
	wire i2s_pkg::gain_t fifo_volume;
	wire i2s_pkg::sample_t proc_left;
	wire i2s_pkg::sample_t proc_right;

	sample_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_fifo (
		.clk(clk),
		.reset(reset),
		.sample_write(sample_write),
		.write_left(write_left),
		.write_right(write_right),
		.write_volume(write_volume),
		.sample_tick(sample_tick),
		.fifo_left(fifo_left),
		.fifo_right(fifo_right),
		.fifo_volume(fifo_volume),
		.fifo_valid(), // silence is already zeros.
		.fifo_update(fifo_update),
		.fifo_full(fifo_full),
		.overflow(overflow),
		.underrun(underrun)
	);

	gain_stage u_gain (
		.clk(clk),
		.reset(reset),
		.fifo_left(fifo_left),
		.fifo_right(fifo_right),
		.fifo_volume(fifo_volume),
		.proc_update(fifo_update),
		.proc_left(proc_left),
		.proc_right(proc_right)
	);

	audio_timing #(
		.CLK_RATE(CLK_RATE),
		.AUDIO_RATE(AUDIO_RATE)
	) u_timing (
		.clk(clk),
		.reset(reset),
		.sample_tick(sample_tick),
		.bclk(bclk),
		.lrclk(lrclk),
		.shift_strobe(shift_strobe),
		.load_strobe(load_strobe)
	);

	i2s_serializer u_serializer (
		.clk(clk),
		.reset(reset),
		.sample_tick(sample_tick),
		.lrclk(lrclk),
		.load_strobe(load_strobe),
		.shift_strobe(shift_strobe),
		.proc_left(proc_left),
		.proc_right(proc_right),
		.sdata(sdata)
	);

endmodule

`default_nettype wire

// ==== source/sample_fifo.sv ====
`default_nettype none

module sample_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input wire clk,
	input wire reset,

	input wire sample_write,
	input wire i2s_pkg::sample_t write_left,
	input wire i2s_pkg::sample_t write_right,
	input wire i2s_pkg::gain_t write_volume,

	input wire sample_tick,

	output i2s_pkg::sample_t fifo_left,
	output i2s_pkg::sample_t fifo_right,
	output i2s_pkg::gain_t fifo_volume,
	output logic fifo_valid,
	output logic fifo_update,
	output logic fifo_full,
	output logic overflow,
	output logic underrun
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

	i2s_pkg::sample_t mem_left [FIFO_DEPTH];
	i2s_pkg::sample_t mem_right [FIFO_DEPTH];
	i2s_pkg::gain_t mem_volume [FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count; // one bit wider to hold FIFO_DEPTH.
	logic do_write;
	logic do_pop;

	assign fifo_full = count == (PTR_W+1)'(FIFO_DEPTH);
	assign do_write = sample_write & ~fifo_full; // writes while full are lost.
	assign do_pop = sample_tick & (count != '0);

	// frame storage.
	always_ff @(posedge clk) begin
		if (do_write) begin
			mem_left[wr_ptr] <= write_left;
			mem_right[wr_ptr] <= write_right;
			mem_volume[wr_ptr] <= write_volume;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			fifo_left <= '0;
			fifo_right <= '0;
			fifo_volume <= '0;
			fifo_valid <= 1'b0;
			fifo_update <= 1'b0;
			overflow <= 1'b0;
			underrun <= 1'b0;
		end else begin
			if (do_write)
				wr_ptr <= wr_ptr + 1'b1; // depth is a power of two, wraps by itself.
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_write, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			if (sample_tick) begin
				fifo_left <= do_pop ? mem_left[rd_ptr] : '0; // silence when empty.
				fifo_right <= do_pop ? mem_right[rd_ptr] : '0;
				fifo_volume <= do_pop ? mem_volume[rd_ptr] : '0;
				fifo_valid <= do_pop;
			end
			fifo_update <= sample_tick; // output changed this cycle.
			overflow <= sample_write & fifo_full;
			underrun <= sample_tick & ~do_pop;
		end
	end

endmodule

`default_nettype wire

// ==== test/golden_frames.txt ====
# columns: test left right volume expected_left expected_right
# test 2 is unity gain, 3 is volume scaling, 4 is saturation
2 1000 -1000 128 1000 -1000
2 32767 -32768 128 32767 -32768
2 1 -1 128 1 -1
2 12345 -23456 128 12345 -23456
3 1000 -1000 64 500 -500
3 3 -3 64 1 -2
3 100 -100 1 0 -1
3 20000 -20000 0 0 0
3 10000 -7 200 15625 -11
3 300 -300 255 597 -598
4 32767 -32768 255 32767 -32768
4 20000 -20000 255 32767 -32768
4 -20000 16384 255 -32768 32640

// ==== test/i2s_checker.sv ====
`default_nettype none

module i2s_checker #(
	parameter int MAX_FRAMES = 32,
	parameter int SILENT_TAIL = 2,
	parameter int FIFO_DEPTH = 4,
	parameter int FRAME_CYCLES = 512
) (
	input wire clk,
	input wire reset,
	input wire sample_write,
	input wire fifo_full,
	input wire overflow,
	input wire underrun,
	input wire bclk,
	input wire lrclk,
	input wire sdata,
	input wire [31:0] frame_total,
	input wire [7:0] test_id [MAX_FRAMES],
	input wire i2s_pkg::sample_t exp_left [MAX_FRAMES],
	input wire i2s_pkg::sample_t exp_right [MAX_FRAMES],
	output int mismatch_count,
	output int fault_count,
	output int frames_checked,
	output logic done
);

	localparam int LEAD_SILENT = 2; // frames sent before the first pop lands.
	localparam int W = i2s_pkg::SAMPLE_WIDTH;

	logic bclk_q;
	logic lrclk_q;
	logic expect_overflow;
	logic write_now;
	logic pop_now;
	logic [W-1:0] word;
	logic [W-1:0] got_left;
	int bit_count;
	int overflow_count;
	int underrun_count;
	int cycle_n;
	int fifo_level;

	function automatic string test_name(input logic [7:0] id);
		case (id)
			8'd2: return "unity gain";
			8'd3: return "volume scaling";
			8'd4: return "saturation";
			default: return "unknown test";
		endcase
	endfunction

	task automatic compare_word(
		input string name,
		input int frame,
		input string channel,
		input logic [W-1:0] expected,
		input logic [W-1:0] actual
	);
		if (actual !== expected) begin
			$display("mismatch %s frame %0d %s: expected %0d, actual %0d",
				name, frame, channel, $signed(expected), $signed(actual));
			mismatch_count++;
		end
	endtask

	// expected frame depends on where it sits in the stream.
	task automatic check_frame(input logic [W-1:0] left, input logic [W-1:0] right);
		int slot;
		string name;
		logic [W-1:0] want_left;
		logic [W-1:0] want_right;
		slot = frames_checked - LEAD_SILENT;
		want_left = '0;
		want_right = '0;
		if (frames_checked < LEAD_SILENT) begin
			name = "reset silence";
		end else if (slot < int'(frame_total)) begin
			name = test_name(test_id[slot]);
			want_left = exp_left[slot];
			want_right = exp_right[slot];
		end else begin
			name = "underrun silence";
		end
		compare_word(name, frames_checked, "left", want_left, left);
		compare_word(name, frames_checked, "right", want_right, right);
		frames_checked++;
	endtask

	// one bit per rising bit clock, msb first.
	task automatic take_bit();
		word = {word[W-2:0], sdata};
		bit_count++;
		if (bit_count == W) begin
			if (lrclk == 1'b0)
				got_left = word; // left half ends, right still to come.
			else
				check_frame(got_left, word);
		end else if (bit_count > W) begin
			$display("more than %0d bit clocks in one word clock half", W);
			fault_count++;
		end
	endtask

	task automatic final_checks();
		if (overflow_count == 0) begin
			$display("no overflow pulse after the write while the FIFO was full");
			fault_count++;
		end
		if (underrun_count == 0) begin
			$display("no underrun pulse after the golden frames ran out");
			fault_count++;
		end
	endtask

	always @(posedge clk) begin
		if (reset) begin
			if ({bclk, lrclk, sdata, overflow, underrun, fifo_full} !== 6'b0) begin
				$display("outputs not low in reset: bclk %b lrclk %b sdata %b",
					bclk, lrclk, sdata);
				$display("  overflow %b underrun %b fifo_full %b", overflow, underrun, fifo_full);
				fault_count++;
			end
			bclk_q = 1'b0;
			lrclk_q = 1'b0;
			expect_overflow = 1'b0;
			word = '0;
			bit_count = 0;
			cycle_n = 0;
			fifo_level = 0;
			done = 1'b0;
		end else if (!done) begin
			cycle_n++;
			if (overflow !== expect_overflow) begin
				$display("mismatch overflow: expected %b, actual %b", expect_overflow, overflow);
				mismatch_count++;
			end
			if (fifo_full !== (fifo_level == FIFO_DEPTH)) begin
				$display("mismatch fifo_full: expected %b, actual %b",
					fifo_level == FIFO_DEPTH, fifo_full);
				mismatch_count++;
			end
			if (overflow === 1'b1)
				overflow_count++;
			// fill level, one pop per frame period from the second one on.
			pop_now = cycle_n > FRAME_CYCLES && cycle_n % FRAME_CYCLES == 1 && fifo_level > 0;
			write_now = sample_write === 1'b1 && fifo_level < FIFO_DEPTH;
			expect_overflow = sample_write === 1'b1 && fifo_level == FIFO_DEPTH; // pulse one cycle later.
			fifo_level = fifo_level + int'(write_now) - int'(pop_now);
			if (underrun === 1'b1) begin
				underrun_count++;
				if (frames_checked < LEAD_SILENT + int'(frame_total) - 1) begin
					$display("underrun while golden frames were still queued");
					fault_count++;
				end
			end
			if (lrclk !== lrclk_q)
				bit_count = 0; // new word clock half.
			if (bclk === 1'b1 && bclk_q === 1'b0)
				take_bit();
			bclk_q = bclk;
			lrclk_q = lrclk;
			if (frames_checked == LEAD_SILENT + int'(frame_total) + SILENT_TAIL) begin
				final_checks();
				done = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== test/tb_i2s_audio_out.sv ====
`default_nettype none

module tb_i2s_audio_out;

	localparam int CLK_RATE = 24576000;
	localparam int AUDIO_RATE = 48000;
	localparam int FIFO_DEPTH = 4;
	localparam int FRAME_CYCLES = CLK_RATE / AUDIO_RATE; // clocks per i2s frame.
	localparam int MAX_FRAMES = 32;
	localparam int SILENT_TAIL = 2;
	localparam int DRIVE_DELAY = 2;
	localparam string GOLDEN_PATH = "test/golden_frames.txt";

	logic clk;
	logic reset;
	logic sample_write;
	i2s_pkg::sample_t write_left;
	i2s_pkg::sample_t write_right;
	i2s_pkg::gain_t write_volume;
	wire fifo_full;
	wire overflow;
	wire underrun;
	wire bclk;
	wire lrclk;
	wire sdata;

	logic [7:0] test_id [MAX_FRAMES];
	i2s_pkg::sample_t in_left [MAX_FRAMES];
	i2s_pkg::sample_t in_right [MAX_FRAMES];
	i2s_pkg::gain_t in_volume [MAX_FRAMES];
	i2s_pkg::sample_t exp_left [MAX_FRAMES];
	i2s_pkg::sample_t exp_right [MAX_FRAMES];
	int frame_count;
	int load_errors;
	int timeout_limit;
	int cycle_count;
	int mismatch_count;
	int fault_count;
	int frames_checked;
	logic checker_done;

	i2s_audio_out #(
		.CLK_RATE(CLK_RATE),
		.AUDIO_RATE(AUDIO_RATE),
		.FIFO_DEPTH(FIFO_DEPTH)
	) uut (
		.clk(clk),
		.reset(reset),
		.sample_write(sample_write),
		.write_left(write_left),
		.write_right(write_right),
		.write_volume(write_volume),
		.fifo_full(fifo_full),
		.overflow(overflow),
		.underrun(underrun),
		.bclk(bclk),
		.lrclk(lrclk),
		.sdata(sdata)
	);

	i2s_checker #(
		.MAX_FRAMES(MAX_FRAMES),
		.SILENT_TAIL(SILENT_TAIL),
		.FIFO_DEPTH(FIFO_DEPTH),
		.FRAME_CYCLES(FRAME_CYCLES)
	) u_checker (
		.clk(clk),
		.reset(reset),
		.sample_write(sample_write),
		.fifo_full(fifo_full),
		.overflow(overflow),
		.underrun(underrun),
		.bclk(bclk),
		.lrclk(lrclk),
		.sdata(sdata),
		.frame_total(frame_count),
		.test_id(test_id),
		.exp_left(exp_left),
		.exp_right(exp_right),
		.mismatch_count(mismatch_count),
		.fault_count(fault_count),
		.frames_checked(frames_checked),
		.done(checker_done)
	);

	task automatic load_golden();
		int fd;
		int n;
		int id, l, r, v, el, er;
		string line;
		fd = $fopen(GOLDEN_PATH, "r");
		if (fd == 0) begin
			$display("cannot open %s", GOLDEN_PATH);
			load_errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (line.len() > 1 && line[0] != "#") begin
				n = $sscanf(line, "%d %d %d %d %d %d", id, l, r, v, el, er);
				if (n != 6) begin
					$display("unreadable golden line: %s", line);
					load_errors++;
				end else if (frame_count == MAX_FRAMES) begin
					$display("golden file holds more than %0d frames", MAX_FRAMES);
					load_errors++;
				end else begin
					test_id[frame_count] = id[7:0];
					in_left[frame_count] = i2s_pkg::sample_t'(l);
					in_right[frame_count] = i2s_pkg::sample_t'(r);
					in_volume[frame_count] = i2s_pkg::gain_t'(v);
					exp_left[frame_count] = i2s_pkg::sample_t'(el);
					exp_right[frame_count] = i2s_pkg::sample_t'(er);
					frame_count++;
				end
			end
		end
		$fclose(fd);
		if (frame_count == 0 && load_errors == 0) begin
			$display("golden file holds no frames");
			load_errors++;
		end
	endtask

	// one golden frame whenever there is room, plus one write into a full FIFO.
	task automatic write_frames();
		int idx;
		logic extra_sent;
		idx = 0;
		extra_sent = 1'b0;
		while (idx < frame_count) begin
			@(posedge clk);
			#DRIVE_DELAY;
			if (!fifo_full) begin
				sample_write = 1'b1;
				write_left = in_left[idx];
				write_right = in_right[idx];
				write_volume = in_volume[idx];
				idx++;
			end else if (!extra_sent) begin
				sample_write = 1'b1;
				write_left = 16'sh5a5a; // must never reach sdata.
				write_right = -16'sd1234;
				write_volume = 8'd128;
				extra_sent = 1'b1;
			end else begin
				sample_write = 1'b0;
			end
		end
		@(posedge clk);
		#DRIVE_DELAY;
		sample_write = 1'b0;
	endtask

	task automatic report_result();
		$display("closing report: %0d frames, %0d mismatches, %0d checker errors, %0d file errors",
			frames_checked, mismatch_count, fault_count, load_errors);
		if (mismatch_count + fault_count + load_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		reset = 1'b0;
		sample_write = 1'b0;
		write_left = '0;
		write_right = '0;
		write_volume = '0;
		frame_count = 0;
		load_errors = 0;
		cycle_count = 0;
		load_golden();
		timeout_limit = (2 + frame_count + SILENT_TAIL + 1) * FRAME_CYCLES + 500;
		#DRIVE_DELAY;
		reset = 1'b1;
		repeat (5) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;
		if (load_errors == 0) begin
			write_frames();
			wait (checker_done === 1'b1);
		end
		report_result();
	end

	// run limit covers lead silence, golden frames and the silent tail.
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= timeout_limit) begin
			$display("timeout after %0d cycles, checker never finished", cycle_count);
			$display("Simulation failed");
			$finish;
		end
	end

endmodule

`default_nettype wire
